// File: source/dma_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, descriptor layout, register map and
// queue depths of the descriptor DMA engine. Modules
// import it inside their body.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package dma_pkg;

  localparam int unsigned AddrWidth = 32;  // Word addresses
  localparam int unsigned DataWidth = 32;
  localparam int unsigned LenWidth  = 16;  // Transfer length in words

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [LenWidth-1:0]  len_t;

  // One word per descriptor field
  localparam int unsigned DescWords = 5;
  localparam int unsigned OffNext   = 0;
  localparam int unsigned OffSrc    = 1;
  localparam int unsigned OffDst    = 2;
  localparam int unsigned OffLen    = 3;
  localparam int unsigned OffFlags  = 4;  // Bit 0 asks for an interrupt

  localparam data_t CompleteWord = 32'h8000_0000;
  localparam addr_t EndOfChain   = '1;

  // Register map
  localparam int unsigned RegDescAddr = 0;  // Write launches a chain
  localparam int unsigned RegStatus   = 1;  // Count in 15:8, busy in 0

  localparam int unsigned InputFifoDepth   = 2;
  localparam int unsigned BufferDepth      = 4;
  localparam int unsigned OutstandingDepth = 4;

endpackage

// File: source/dma_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous circular-buffer FIFO with a usage count.
// The entry type is a parameter, so one block queues
// addresses, data words and read owners.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dma_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned Depth   = 2
) (
  input  logic                       i_idma_backend,
  input  logic                       reset_i,
  input  logic                       push_i,
  input  entry_t                     data_i,
  output logic                       full_o,
  input  logic                       pop_i,
  output entry_t                     data_o,
  output logic                       empty_o,
  output logic [$clog2(Depth+1)-1:0] usage_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  entry_t                     mem_q [Depth];
  logic [PtrWidth-1:0]        wr_ptr_q, rd_ptr_q;
  logic [$clog2(Depth+1)-1:0] count_q;
  logic                       do_push, do_pop;

  assign full_o  = (count_q == Depth);
  assign empty_o = (count_q == '0);
  assign usage_o = count_q;
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i & ~full_o;  // A push into a full queue is lost
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push != do_pop) count_q <= do_push ? count_q + 1'b1 : count_q - 1'b1;
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// File: source/desc_frontend.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Descriptor frontend. Takes chain addresses from the
// register port, fetches each descriptor, hands the copy
// to the backend, then writes the completion word back
// and raises the interrupt when the descriptor asks.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module desc_frontend (
  input  logic           i_idma_backend,
  input  logic           reset_i,
  input  logic           reg_valid_i,
  input  logic           reg_write_i,
  input  dma_pkg::addr_t reg_addr_i,
  input  dma_pkg::data_t reg_wdata_i,
  output dma_pkg::data_t reg_rdata_o,
  output logic           reg_ready_o,
  output logic           fe_req_o,
  output logic           fe_we_o,
  output dma_pkg::addr_t fe_addr_o,
  output dma_pkg::data_t fe_wdata_o,
  input  logic           fe_gnt_i,
  input  logic           fe_rvalid_i,
  input  dma_pkg::data_t fe_rdata_i,
  output dma_pkg::addr_t xfer_src_o,
  output dma_pkg::addr_t xfer_dst_o,
  output dma_pkg::len_t  xfer_len_o,
  output logic           xfer_valid_o,
  input  logic           xfer_ready_i,
  input  logic           done_valid_i,
  output logic           done_ready_o,
  input  logic           be_busy_i,
  output logic           irq_o
);
  import dma_pkg::*;

  localparam int unsigned WordCntWidth = $clog2(DescWords + 1);

  typedef enum logic [2:0] {Idle, Fetch, Launch, Wait, WriteBack} state_e;

  state_e                  state_q;
  addr_t                   cur_addr_q, launch_addr;
  data_t                   desc_q [DescWords];
  data_t                   reg_rdata_q, status;
  logic [WordCntWidth-1:0] issued_q, received_q;
  logic [7:0]              done_cnt_q;
  logic                    reg_ready_q, irq_q, reg_accept, busy;
  logic                    launch_empty, launch_pop;

  // Each access is taken once and acknowledged in the next cycle
  assign reg_accept = reg_valid_i & ~reg_ready_q;
  assign busy       = (state_q != Idle) | ~launch_empty | be_busy_i;
  assign status     = {16'b0, done_cnt_q, 7'b0, busy};
  assign launch_pop = (state_q == Idle) & ~launch_empty;

  dma_fifo #(
    .entry_t (addr_t),
    .Depth   (InputFifoDepth)
  ) u_launch_fifo (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .push_i         (reg_accept & reg_write_i & (reg_addr_i == RegDescAddr)),
    .data_i         (reg_wdata_i),
    .full_o         (),
    .pop_i          (launch_pop),
    .data_o         (launch_addr),
    .empty_o        (launch_empty),
    .usage_o        ()
  );

  assign fe_req_o   = ((state_q == Fetch) && (issued_q != DescWords)) || (state_q == WriteBack);
  assign fe_we_o    = (state_q == WriteBack);
  assign fe_addr_o  = cur_addr_q + (fe_we_o ? AddrWidth'(OffFlags) : AddrWidth'(issued_q));
  assign fe_wdata_o = CompleteWord;

  assign xfer_src_o   = desc_q[OffSrc];
  assign xfer_dst_o   = desc_q[OffDst];
  assign xfer_len_o   = desc_q[OffLen][LenWidth-1:0];
  assign xfer_valid_o = (state_q == Launch);
  assign done_ready_o = (state_q == Wait);
  assign reg_ready_o  = reg_ready_q;
  assign reg_rdata_o  = reg_rdata_q;
  assign irq_o        = irq_q;

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      state_q     <= Idle;
      issued_q    <= '0;
      received_q  <= '0;
      done_cnt_q  <= '0;
      reg_ready_q <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      reg_ready_q <= reg_accept;
      irq_q       <= 1'b0;
      unique case (state_q)
        Idle: if (!launch_empty) state_q <= Fetch;
        Fetch: begin
          if (fe_gnt_i) issued_q <= issued_q + 1'b1;
          if (fe_rvalid_i) begin
            received_q <= received_q + 1'b1;
            if (received_q == WordCntWidth'(DescWords - 1)) state_q <= Launch;
          end
        end
        Launch: if (xfer_ready_i) state_q <= Wait;
        Wait: if (done_valid_i) state_q <= WriteBack;
        WriteBack: if (fe_gnt_i) begin
          irq_q      <= desc_q[OffFlags][0];
          done_cnt_q <= done_cnt_q + 1'b1;
          issued_q   <= '0;
          received_q <= '0;
          state_q    <= (desc_q[OffNext] == EndOfChain) ? Idle : Fetch;  // Follow the chain
        end
        default: state_q <= Idle;
      endcase
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (launch_pop) cur_addr_q <= launch_addr;
    else if ((state_q == WriteBack) && fe_gnt_i) cur_addr_q <= desc_q[OffNext];
    if ((state_q == Fetch) && fe_rvalid_i) desc_q[received_q] <= fe_rdata_i;
    if (reg_accept) reg_rdata_q <= (!reg_write_i && reg_addr_i == RegStatus) ? status : '0;
  end

endmodule

// File: source/copy_backend.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Word-copy backend. Reads source words into a small
// data FIFO and writes them to the destination, one
// transfer at a time, then reports completion.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module copy_backend (
  input  logic           i_idma_backend,
  input  logic           reset_i,
  input  dma_pkg::addr_t xfer_src_i,
  input  dma_pkg::addr_t xfer_dst_i,
  input  dma_pkg::len_t  xfer_len_i,
  input  logic           xfer_valid_i,
  output logic           xfer_ready_o,
  output logic           done_valid_o,
  input  logic           done_ready_i,
  output logic           be_req_o,
  output logic           be_we_o,
  output dma_pkg::addr_t be_addr_o,
  output dma_pkg::data_t be_wdata_o,
  input  logic           be_gnt_i,
  input  logic           be_rvalid_i,
  input  dma_pkg::data_t be_rdata_i,
  output logic           busy_o
);
  import dma_pkg::*;

  localparam int unsigned CntWidth = $clog2(BufferDepth + 1);

  addr_t               rd_addr_q, wr_addr_q;
  len_t                rd_left_q, wr_left_q;
  logic [CntWidth-1:0] inflight_q, buf_usage;
  logic                active_q, done_q, hold_q, hold_we_q, buf_empty;
  logic                rd_want, wr_want, rd_gnt, wr_gnt, accept;

  // Reads stop once buffered plus outstanding words fill the FIFO
  assign rd_want = active_q && (rd_left_q != '0) && ((buf_usage + inflight_q) < BufferDepth);
  assign wr_want = active_q & ~buf_empty;

  // Writes win, except over a read already waiting for its grant
  assign be_we_o   = hold_q ? hold_we_q : wr_want;
  assign be_req_o  = wr_want | rd_want;
  assign be_addr_o = be_we_o ? wr_addr_q : rd_addr_q;
  assign rd_gnt    = be_gnt_i & ~be_we_o;
  assign wr_gnt    = be_gnt_i & be_we_o;

  assign accept       = xfer_valid_i & xfer_ready_o;
  assign xfer_ready_o = ~active_q & ~done_q;
  assign done_valid_o = done_q;
  assign busy_o       = active_q | done_q;

  dma_fifo #(
    .entry_t (data_t),
    .Depth   (BufferDepth)
  ) u_data_fifo (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .push_i         (be_rvalid_i),
    .data_i         (be_rdata_i),
    .full_o         (),
    .pop_i          (wr_gnt),
    .data_o         (be_wdata_o),
    .empty_o        (buf_empty),
    .usage_o        (buf_usage)
  );

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      active_q   <= 1'b0;
      done_q     <= 1'b0;
      hold_q     <= 1'b0;
      hold_we_q  <= 1'b0;
      inflight_q <= '0;
    end else begin
      hold_q    <= be_req_o & ~be_gnt_i;
      hold_we_q <= be_we_o;
      unique case ({rd_gnt, be_rvalid_i})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
      if (accept) begin
        active_q <= (xfer_len_i != '0);
        done_q   <= (xfer_len_i == '0);  // Empty copy is done at once
      end
      if (wr_gnt && (wr_left_q == len_t'(1))) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
      if (done_q && done_ready_i) done_q <= 1'b0;
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (accept) begin
      rd_addr_q <= xfer_src_i;
      wr_addr_q <= xfer_dst_i;
      rd_left_q <= xfer_len_i;
      wr_left_q <= xfer_len_i;
    end else begin
      if (rd_gnt) rd_addr_q <= rd_addr_q + 1'b1;
      if (rd_gnt) rd_left_q <= rd_left_q - 1'b1;
      if (wr_gnt) wr_addr_q <= wr_addr_q + 1'b1;
      if (wr_gnt) wr_left_q <= wr_left_q - 1'b1;
    end
  end

endmodule

// File: source/mem_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter joining frontend and backend on
// one memory port. Read owners are queued so that each
// read response goes back to the port that asked.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_arbiter (
  input  logic           i_idma_backend,
  input  logic           reset_i,
  input  logic           fe_req_i,
  input  logic           fe_we_i,
  input  dma_pkg::addr_t fe_addr_i,
  input  dma_pkg::data_t fe_wdata_i,
  output logic           fe_gnt_o,
  output logic           fe_rvalid_o,
  output dma_pkg::data_t fe_rdata_o,
  input  logic           be_req_i,
  input  logic           be_we_i,
  input  dma_pkg::addr_t be_addr_i,
  input  dma_pkg::data_t be_wdata_i,
  output logic           be_gnt_o,
  output logic           be_rvalid_o,
  output dma_pkg::data_t be_rdata_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output dma_pkg::addr_t mem_addr_o,
  output dma_pkg::data_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  dma_pkg::data_t mem_rdata_i
);
  import dma_pkg::*;

  logic fe_ok, be_ok, pick_be, sel_q, locked_q;
  logic own_full, own_head, grant_rd;

  // A read competes only while its owner can still be queued
  assign fe_ok = fe_req_i & (fe_we_i | ~own_full);
  assign be_ok = be_req_i & (be_we_i | ~own_full);

  always_comb begin
    if (locked_q) pick_be = sel_q;  // Stalled request stays on the bus
    else if (fe_ok && be_ok) pick_be = ~sel_q;
    else pick_be = be_ok;
  end

  assign mem_req_o   = pick_be ? be_ok : fe_ok;
  assign mem_we_o    = pick_be ? be_we_i : fe_we_i;
  assign mem_addr_o  = pick_be ? be_addr_i : fe_addr_i;
  assign mem_wdata_o = pick_be ? be_wdata_i : fe_wdata_i;
  assign fe_gnt_o    = mem_gnt_i & mem_req_o & ~pick_be;
  assign be_gnt_o    = mem_gnt_i & mem_req_o & pick_be;
  assign grant_rd    = mem_gnt_i & mem_req_o & ~mem_we_o;

  always_ff @(posedge i_idma_backend) begin
    if (reset_i) begin
      sel_q    <= 1'b1;
      locked_q <= 1'b0;
    end else begin
      locked_q <= mem_req_o & ~mem_gnt_i;
      if (mem_req_o) sel_q <= pick_be;
    end
  end

  dma_fifo #(
    .entry_t (logic),
    .Depth   (OutstandingDepth)
  ) u_owner_fifo (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .push_i         (grant_rd),
    .data_i         (pick_be),
    .full_o         (own_full),
    .pop_i          (mem_rvalid_i),
    .data_o         (own_head),
    .empty_o        (),
    .usage_o        ()
  );

  assign fe_rvalid_o = mem_rvalid_i & ~own_head;
  assign be_rvalid_o = mem_rvalid_i & own_head;
  assign fe_rdata_o  = mem_rdata_i;
  assign be_rdata_o  = mem_rdata_i;

endmodule

// File: source/dma_desc_wrap.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the descriptor DMA engine. Frontend and
// backend share the single memory master port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module dma_desc_wrap (
  input  logic           i_idma_backend,
  input  logic           reset_i,
  input  logic           reg_valid_i,
  input  logic           reg_write_i,
  input  dma_pkg::addr_t reg_addr_i,
  input  dma_pkg::data_t reg_wdata_i,
  output dma_pkg::data_t reg_rdata_o,
  output logic           reg_ready_o,
  output logic           mem_req_o,
  output logic           mem_we_o,
  output dma_pkg::addr_t mem_addr_o,
  output dma_pkg::data_t mem_wdata_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  dma_pkg::data_t mem_rdata_i,
  output logic           irq_o
);
  import dma_pkg::*;

  addr_t fe_addr, be_addr, xfer_src, xfer_dst;
  data_t fe_wdata, fe_rdata, be_wdata, be_rdata;
  len_t  xfer_len;
  logic  fe_req, fe_we, fe_gnt, fe_rvalid;
  logic  be_req, be_we, be_gnt, be_rvalid;
  logic  xfer_valid, xfer_ready, done_valid, done_ready, be_busy;

  // Register port and irq_o connect by name
  desc_frontend u_frontend (
    .*,
    .fe_req_o     (fe_req),     .fe_we_o      (fe_we),
    .fe_addr_o    (fe_addr),    .fe_wdata_o   (fe_wdata),
    .fe_gnt_i     (fe_gnt),     .fe_rvalid_i  (fe_rvalid),
    .fe_rdata_i   (fe_rdata),   .be_busy_i    (be_busy),
    .xfer_src_o   (xfer_src),   .xfer_dst_o   (xfer_dst),
    .xfer_len_o   (xfer_len),   .xfer_valid_o (xfer_valid),
    .xfer_ready_i (xfer_ready), .done_valid_i (done_valid),
    .done_ready_o (done_ready)
  );

  copy_backend u_backend (
    .*,
    .xfer_src_i   (xfer_src),   .xfer_dst_i   (xfer_dst),
    .xfer_len_i   (xfer_len),   .xfer_valid_i (xfer_valid),
    .xfer_ready_o (xfer_ready), .done_valid_o (done_valid),
    .done_ready_i (done_ready), .busy_o       (be_busy),
    .be_req_o     (be_req),     .be_we_o      (be_we),
    .be_addr_o    (be_addr),    .be_wdata_o   (be_wdata),
    .be_gnt_i     (be_gnt),     .be_rvalid_i  (be_rvalid),
    .be_rdata_i   (be_rdata)
  );

  // Shared memory port connects by name
  mem_arbiter u_arbiter (
    .*,
    .fe_req_i    (fe_req),    .fe_we_i     (fe_we),
    .fe_addr_i   (fe_addr),   .fe_wdata_i  (fe_wdata),
    .fe_gnt_o    (fe_gnt),    .fe_rvalid_o (fe_rvalid),
    .fe_rdata_o  (fe_rdata),  .be_req_i    (be_req),
    .be_we_i     (be_we),     .be_addr_i   (be_addr),
    .be_wdata_i  (be_wdata),  .be_gnt_o    (be_gnt),
    .be_rvalid_o (be_rvalid), .be_rdata_o  (be_rdata)
  );

endmodule

// File: tb/tb_mem_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioural word memory for the DMA testbench.
// Grants at random, returns read data two cycles
// after the grant, and has a load port for setup.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_mem_model (
  input  logic        i_idma_backend,
  input  logic        reset_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  input  logic        load_en_i,
  input  logic [11:0] load_addr_i,
  input  logic [31:0] load_data_i
);

  logic [31:0] mem_q [4096];
  integer      seed = 32'hc94c_94bc;
  logic        ready_q = 1'b0;
  logic [1:0]  vld_q = 2'b00;  // Read response pipeline
  logic [31:0] data1_q, data2_q;

  assign gnt_o    = req_i & ready_q;
  assign rvalid_o = vld_q[1];
  assign rdata_o  = data2_q;

  always @(posedge i_idma_backend) begin
    ready_q <= (($random(seed) & 3) != 0);  // Stall about one cycle in four
    if (reset_i) vld_q <= 2'b00;
    else vld_q <= {vld_q[0], req_i & gnt_o & ~we_i};
    data1_q <= mem_q[addr_i[11:0]];
    data2_q <= data1_q;
    if (load_en_i) mem_q[load_addr_i] <= load_data_i;
    else if (req_i && gnt_o && we_i) mem_q[addr_i[11:0]] <= wdata_i;
  end

endmodule

// File: tb/tb_dma_desc_wrap.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the descriptor DMA engine. Builds chains
// in memory, launches them over the register port and
// compares memory with a reference walk of each chain.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_dma_desc_wrap;
  import dma_pkg::*;

  localparam int MemWords = 4096;

  logic        i_idma_backend, reset_i;
  logic        reg_valid_i, reg_write_i, reg_ready_o, irq_o;
  addr_t       reg_addr_i, mem_addr_o;
  data_t       reg_wdata_i, reg_rdata_o, mem_wdata_o, mem_rdata_i;
  logic        mem_req_o, mem_we_o, mem_gnt_i, mem_rvalid_i;
  logic        load_en;
  logic [11:0] load_addr;
  data_t       load_data;
  data_t       shadow [MemWords];
  int          errors = 0;
  int          timeouts = 0;
  int          irq_seen = 0;
  int          irq_expected = 0;
  int          done_expected = 0;

  dma_desc_wrap u_dma_desc_wrap (.*);

  tb_mem_model u_mem (
    .i_idma_backend (i_idma_backend),
    .reset_i        (reset_i),
    .req_i          (mem_req_o),
    .we_i           (mem_we_o),
    .addr_i         (mem_addr_o),
    .wdata_i        (mem_wdata_o),
    .gnt_o          (mem_gnt_i),
    .rvalid_o       (mem_rvalid_i),
    .rdata_o        (mem_rdata_i),
    .load_en_i      (load_en),
    .load_addr_i    (load_addr),
    .load_data_i    (load_data)
  );

  initial begin
    i_idma_backend = 1'b0;
    forever #2 i_idma_backend = ~i_idma_backend;
  end

  always @(negedge i_idma_backend) begin
    if (!reset_i && irq_o) irq_seen++;  // One count per pulse cycle
  end

  task automatic check_value(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Pattern covers all twelve address bits
  function automatic data_t fill_word(input logic [11:0] a);
    return {8'hd5, a, ~a};
  endfunction

  // Reference walk of a chain over the shadow image
  function automatic void apply_chain(input addr_t head);
    addr_t at, src, dst;
    int    len;
    at = head;
    while (at != EndOfChain) begin
      src = shadow[12'(at + OffSrc)];
      dst = shadow[12'(at + OffDst)];
      len = int'(shadow[12'(at + OffLen)][15:0]);
      for (int i = 0; i < len; i++) begin
        shadow[12'(dst + i)] = shadow[12'(src + i)];
      end
      if (shadow[12'(at + OffFlags)][0]) irq_expected++;
      shadow[12'(at + OffFlags)] = CompleteWord;
      done_expected++;
      at = shadow[12'(at + OffNext)];
    end
  endfunction

  task automatic put_word(input logic [11:0] a, input data_t d);
    @(posedge i_idma_backend);
    load_en   <= 1'b1;
    load_addr <= a;
    load_data <= d;
    @(posedge i_idma_backend);
    load_en   <= 1'b0;
    shadow[a] = d;
  endtask

  task automatic put_desc(input logic [11:0] at, input addr_t next, input addr_t src,
                          input addr_t dst, input int len, input logic want_irq);
    put_word(12'(at + OffNext), next);
    put_word(12'(at + OffSrc), src);
    put_word(12'(at + OffDst), dst);
    put_word(12'(at + OffLen), data_t'(len));
    put_word(12'(at + OffFlags), {31'b0, want_irq});
  endtask

  task automatic reg_access(input logic wr, input addr_t a, input data_t d, output data_t rd);
    int n;
    @(posedge i_idma_backend);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= a;
    reg_wdata_i <= d;
    n = 0;
    @(negedge i_idma_backend);
    while (!reg_ready_o && n < 20) begin
      @(negedge i_idma_backend);
      n++;
    end
    if (!reg_ready_o) begin
      timeouts++;
      $display("Timeout: register access at offset %0d was never acknowledged", a);
    end
    rd = reg_rdata_o;
    @(posedge i_idma_backend);
    reg_valid_i <= 1'b0;
  endtask

  task automatic launch(input addr_t head);
    data_t unused;
    apply_chain(head);
    reg_access(1'b1, RegDescAddr, head, unused);
  endtask

  task automatic finish_check(input string what);
    data_t st;
    int    polls;
    polls = 0;
    reg_access(1'b0, RegStatus, '0, st);
    while (st[0] && polls < 500) begin
      reg_access(1'b0, RegStatus, '0, st);
      polls++;
    end
    if (st[0]) begin
      timeouts++;
      $display("Timeout: engine still busy after %0d status reads in %s", polls, what);
    end
    for (int a = 0; a < MemWords; a++) begin
      check_value(u_mem.mem_q[a], shadow[a], $sformatf("%s, word %0h", what, a));
    end
    check_value(data_t'(st[15:8]), data_t'(done_expected[7:0]), {what, ", completed count"});
    check_value(data_t'(irq_seen), data_t'(irq_expected), {what, ", interrupt count"});
  endtask

  initial begin
    data_t st;
    reset_i     = 1'b1;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    repeat (2) @(posedge i_idma_backend);
    reset_i <= 1'b0;

    @(negedge i_idma_backend);
    check_value(data_t'(irq_o), '0, "irq after reset");
    check_value(data_t'(mem_req_o), '0, "memory request after reset");
    reg_access(1'b0, RegStatus, '0, st);
    check_value(st, '0, "status after reset");

    for (int a = 0; a < MemWords; a++) begin
      put_word(12'(a), fill_word(12'(a)));
    end

    put_desc(12'h100, EndOfChain, 32'h400, 32'h500, 8, 1'b1);
    launch(32'h100);
    finish_check("single descriptor");

    put_desc(12'h110, 32'h118, 32'h410, 32'h510, 4, 1'b0);
    put_desc(12'h118, 32'h120, 32'h420, 32'h520, 5, 1'b0);
    put_desc(12'h120, EndOfChain, 32'h430, 32'h530, 6, 1'b1);
    launch(32'h110);
    finish_check("three-descriptor chain");

    put_desc(12'h130, EndOfChain, 32'h440, 32'h540, 0, 1'b0);
    launch(32'h130);
    finish_check("zero-length descriptor");

    // Second launch waits in the queue behind the first
    put_desc(12'h140, EndOfChain, 32'h450, 32'h550, 3, 1'b1);
    put_desc(12'h148, 32'h150, 32'h550, 32'h560, 2, 1'b0);  // Copies the first chain's output
    put_desc(12'h150, EndOfChain, 32'h470, 32'h570, 7, 1'b1);
    launch(32'h140);
    launch(32'h148);
    finish_check("back-to-back launches");

    put_desc(12'h160, EndOfChain, 32'h600, 32'h700, 40, 1'b1);
    launch(32'h160);
    finish_check("long copy");

    $display("Finished with %0d value errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: src.f
source/dma_pkg.sv
source/dma_fifo.sv
source/desc_frontend.sv
source/copy_backend.sv
source/mem_arbiter.sv
source/dma_desc_wrap.sv
tb/tb_mem_model.sv
tb/tb_dma_desc_wrap.sv

// File: Makefile
# Verilator build and run of the descriptor DMA testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_desc_wrap
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
